//--- files.f
hw/itch_pkg.sv
hw/msg_framer.sv
hw/payload_fifo.sv
hw/order_decoder.sv
hw/itch_parser_top.sv
bench/itch_parser_assertions.sv
bench/itch_parser_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the parser testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module itch_parser_tb \
    -f files.f \
    -o itch_parser_sim

sim_output="$(./obj_dir/itch_parser_sim 2>&1)" || true
echo "$sim_output"

if grep -qx "Done: no errors" <<< "$sim_output"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- bench/itch_parser_tb.sv
`timescale 1ns/100ps
`default_nettype none

module itch_parser_tb
    import itch_pkg::*;
();

    localparam int FIFO_DEPTH    = 8;
    localparam int ORDER_CREDITS = 2;
    localparam int LONG_PAUSE    = 400;
    localparam int NUM_MSGS      = 14;

    // Payload positions after the type byte, each the last byte of its field
    localparam int POS_STOCK     = 1;
    localparam int POS_ORDER_ID  = 17;
    localparam int POS_SIDE      = 18;
    localparam int POS_ADD_QTY   = 22;
    localparam int POS_EXEC_QTY  = 21;
    localparam int POS_PRICE_LO  = 34;
    localparam int ADD_LEN       = 35;
    localparam int EXEC_LEN      = 22;

    typedef struct packed {
        logic [1:0] zeros;      // zero bytes sent ahead of the message
        byte_t      msg_type;
        byte_t      length;     // only used for skipped types
        stock_id_t  stock;
        order_id_t  order_id;
        quantity_t  quantity;
        price_t     price;
        byte_t      side;
    } msg_entry_t;

    localparam msg_entry_t MSG_TABLE [NUM_MSGS] = '{
        '{2'd0, 8'h82, 8'd0,  2'd1, 8'h11, 8'h64, 16'h1234, 8'h41},
        '{2'd0, 8'h86, 8'd0,  2'd2, 8'h12, 8'hC8, 16'hBEEF, 8'h53},
        '{2'd1, 8'h2A, 8'd0,  2'd1, 8'h11, 8'h20, 16'h0000, 8'h00},
        '{2'd0, 8'h22, 8'd1,  2'd0, 8'h00, 8'h00, 16'h0000, 8'h00},
        '{2'd0, 8'hA1, 8'd0,  2'd2, 8'h12, 8'h08, 16'h0000, 8'h41},
        '{2'd2, 8'hAA, 8'd30, 2'd3, 8'h99, 8'h99, 16'h9999, 8'h41},
        '{2'd0, 8'h82, 8'd0,  2'd0, 8'h20, 8'h01, 16'h0102, 8'h40},
        '{2'd0, 8'h86, 8'd0,  2'd3, 8'h21, 8'h7F, 16'h8000, 8'h41},
        '{2'd0, 8'h2A, 8'd0,  2'd3, 8'h21, 8'h33, 16'hFFFF, 8'h41},
        '{2'd3, 8'h22, 8'd40, 2'd1, 8'h55, 8'h55, 16'h5555, 8'h41},
        '{2'd0, 8'hA1, 8'd0,  2'd0, 8'h20, 8'h01, 16'h0000, 8'h00},
        '{2'd0, 8'h82, 8'd0,  2'd2, 8'hFE, 8'h80, 16'h00FF, 8'hC1},
        '{2'd0, 8'h86, 8'd0,  2'd3, 8'hFF, 8'hFF, 16'hFFFF, 8'h41},
        '{2'd1, 8'h2A, 8'd0,  2'd2, 8'hFE, 8'h40, 16'h0000, 8'h53}
    };

    logic       clk_in       = 1'b0;
    logic       reset_in     = 1'b1;
    byte_t      byte_in      = 8'h00;
    logic       byte_valid   = 1'b0;
    logic       order_credit = 1'b0;
    logic       byte_ready;
    order_rec_t order_out;
    logic       order_valid;

    integer     seed = 32'hdb5b_54bd;
    byte_t      stream_q [$];
    order_rec_t expect_q [$];
    int         expect_total   = 0;
    int         received       = 0;
    int         outstanding    = 0;
    int         credit_wait    = 0;
    int         timeout_cycles = 0;
    int         drain_cycles   = 0;
    logic       stalled        = 1'b0;
    int         idx;

    always #4 clk_in = ~clk_in;

    itch_parser_top #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .ORDER_CREDITS (ORDER_CREDITS)
    ) itch_parser_top_inst (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .byte_in       (byte_in),
        .byte_valid    (byte_valid),
        .order_credit  (order_credit),
        .byte_ready    (byte_ready),
        .order_out     (order_out),
        .order_valid   (order_valid)
    );

    ////////////////////////////////////////
    // Failure handling and compares
    ////////////////////////////////////////

    task automatic abort_run;
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_record(input order_rec_t got, input order_rec_t exp);
        if (got !== exp) begin
            $display("[ERROR] order_out: got %h expected %h (record %0d)", got, exp, received);
            abort_run();
        end
    endtask

    task automatic check_request(input request_e got, input request_e exp);
        if (got !== exp) begin
            $display("[ERROR] order_out.request: got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] byte_ready: got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // Message table to byte stream
    ////////////////////////////////////////

    task automatic build_stream;
        msg_entry_t e;
        order_rec_t rec;
        byte_t      b;
        logic       is_add;
        int         len;
        for (int m = 0; m < NUM_MSGS; m++) begin
            e = MSG_TABLE[m];
            repeat (e.zeros) stream_q.push_back(8'h00);
            is_add = (e.msg_type == 8'h82) || (e.msg_type == 8'h86);
            if (is_add || e.msg_type == 8'h2A || e.msg_type == 8'hA1) begin
                len = is_add ? ADD_LEN : EXEC_LEN;
                stream_q.push_back(8'(len + 1));
                stream_q.push_back(e.msg_type);
                for (int p = 0; p < len; p++) begin
                    b = 8'($random(seed));
                    if (p == POS_STOCK) b = {b[7:2], e.stock};
                    if (p == POS_ORDER_ID) b = e.order_id;
                    if (is_add && p == POS_SIDE) b = e.side;
                    if (p == (is_add ? POS_ADD_QTY : POS_EXEC_QTY)) b = e.quantity;
                    if (is_add && p == POS_PRICE_LO - 1) b = e.price[15:8];
                    if (is_add && p == POS_PRICE_LO) b = e.price[7:0];
                    stream_q.push_back(b);
                end
                if (is_add) begin
                    rec.request = REQ_ADD;
                end else if (e.msg_type == 8'h2A) begin
                    rec.request = REQ_EXECUTE;
                end else begin
                    rec.request = REQ_CANCEL;
                end
                rec.stock    = e.stock;
                rec.order_id = e.order_id;
                rec.quantity = e.quantity;
                rec.price    = is_add ? e.price : 16'h0000;
                rec.buy      = is_add && (e.side == 8'h41);
                expect_q.push_back(rec);
            end else begin
                // Skipped type, length counts the type byte
                stream_q.push_back(e.length);
                stream_q.push_back(e.msg_type);
                for (int p = 1; p < int'(e.length); p++) begin
                    stream_q.push_back(8'($random(seed)));
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Record monitor and credit return
    ////////////////////////////////////////

    always @(negedge clk_in) begin : monitor_credits
        order_rec_t exp;
        order_credit = 1'b0;
        if (!reset_in) begin
            if (order_valid) begin
                if (expect_q.size() == 0) begin
                    $display("Extra record arrived after all expected ones: %h", order_out);
                    abort_run();
                end else begin
                    exp = expect_q.pop_front();
                    check_request(order_out.request, exp.request);
                    check_record(order_out, exp);
                    received++;
                    outstanding++;
                    if (outstanding > ORDER_CREDITS) begin
                        $display("More than %0d records outstanding without credits",
                                 ORDER_CREDITS);
                        abort_run();
                    end
                    // Withhold credits once so the FIFO backs up
                    if (received == 2) credit_wait = LONG_PAUSE;
                end
            end
            if (credit_wait > 0) begin
                credit_wait--;
            end else if (outstanding > 0) begin
                order_credit = 1'b1;
                outstanding--;
                credit_wait = $random(seed) & 7;
            end
        end
    end

    initial begin : watchdog
        wait (timeout_cycles != 0);
        repeat (timeout_cycles) @(posedge clk_in);
        $display("Watchdog timeout with %0d of %0d records received", received, expect_total);
        abort_run();
    end

    ////////////////////////////////////////
    // Reset and byte driver
    ////////////////////////////////////////

    initial begin
        build_stream();
        expect_total   = expect_q.size();
        timeout_cycles = stream_q.size() * 40 + LONG_PAUSE;
        repeat (16) @(negedge clk_in);
        reset_in = 1'b0;
        @(negedge clk_in);
        check_ready(byte_ready, 1'b1);
        idx = 0;
        while (idx < stream_q.size()) begin
            @(negedge clk_in);
            if (($random(seed) & 3) == 0) begin
                byte_valid = 1'b0;
            end else begin
                byte_valid = 1'b1;
                byte_in    = stream_q[idx];
                // Ready only depends on registered state, so it holds until the edge
                if (byte_ready) begin
                    idx++;
                end else begin
                    stalled = 1'b1;
                end
            end
        end
        @(negedge clk_in);
        byte_valid = 1'b0;
        while (received < expect_total && drain_cycles < LONG_PAUSE) begin
            @(negedge clk_in);
            drain_cycles++;
        end
        repeat (200) @(negedge clk_in);
        if (received != expect_total || expect_q.size() != 0) begin
            $display("Record count wrong: %0d received, %0d expected", received, expect_total);
            abort_run();
        end else if (!stalled) begin
            $display("Input was never stalled while order credits were held back");
            abort_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/itch_parser_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module itch_parser_assertions #(
    parameter int CREDIT_W     = 2,
    parameter bit SINGLE_PULSE = 1'b0
) (
    input wire                clk_in,
    input wire                reset_in,
    input wire                strobe,
    input wire [CREDIT_W-1:0] credits
);

    // Every transfer spends a credit that is really there
    spend_needs_credit: assert property (
        @(posedge clk_in) disable iff (reset_in)
        strobe |-> (credits != '0)
    ) else $error("transfer issued with no credit left");

    // Output records are one-cycle pulses
    single_cycle_pulse: assert property (
        @(posedge clk_in) disable iff (reset_in)
        (SINGLE_PULSE && strobe) |=> !strobe
    ) else $error("strobe held high for more than one cycle");

endmodule

////////////////////////////////////////
// Binding to the credit links
////////////////////////////////////////

bind msg_framer itch_parser_assertions #(
    .CREDIT_W     (CREDIT_W),
    .SINGLE_PULSE (1'b0)
) framer_checks (
    .clk_in       (clk_in),
    .reset_in     (reset_in),
    .strobe       (push),
    .credits      (credits)
);

bind order_decoder itch_parser_assertions #(
    .CREDIT_W     (CREDIT_W),
    .SINGLE_PULSE (1'b1)
) decoder_checks (
    .clk_in       (clk_in),
    .reset_in     (reset_in),
    .strobe       (order_valid),
    .credits      (credits)
);

`default_nettype wire

//--- hw/itch_parser_top.sv
`timescale 1ns/100ps
`default_nettype none

module itch_parser_top
    import itch_pkg::*;
#(
    parameter int FIFO_DEPTH    = 8,
    parameter int ORDER_CREDITS = 2
) (
    input  wire        clk_in,
    input  wire        reset_in,
    input  wire byte_t byte_in,
    input  wire        byte_valid,
    input  wire        order_credit,
    output logic       byte_ready,
    output order_rec_t order_out,
    output logic       order_valid
);

    // Framer to FIFO
    logic         push;
    tagged_byte_t push_data;
    logic         credit_return;

    // FIFO to decoder
    tagged_byte_t fifo_data;
    logic         fifo_empty;
    logic         pop;

    msg_framer #(
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) msg_framer_inst (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .byte_in       (byte_in),
        .byte_valid    (byte_valid),
        .credit_return (credit_return),
        .byte_ready    (byte_ready),
        .push          (push),
        .push_data     (push_data)
    );

    payload_fifo #(
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) payload_fifo_inst (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .push          (push),
        .push_data     (push_data),
        .pop           (pop),
        .fifo_data     (fifo_data),
        .fifo_empty    (fifo_empty),
        .credit_return (credit_return)
    );

    order_decoder #(
        .ORDER_CREDITS (ORDER_CREDITS)
    ) order_decoder_inst (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .fifo_data     (fifo_data),
        .fifo_empty    (fifo_empty),
        .order_credit  (order_credit),
        .pop           (pop),
        .order_out     (order_out),
        .order_valid   (order_valid)
    );

endmodule

`default_nettype wire

//--- hw/order_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module order_decoder
    import itch_pkg::*;
#(
    parameter int ORDER_CREDITS = 2
) (
    input  wire          clk_in,
    input  wire          reset_in,
    input  tagged_byte_t fifo_data,
    input  wire          fifo_empty,
    input  wire          order_credit,
    output logic         pop,
    output order_rec_t   order_out,
    output logic         order_valid
);

    localparam int CREDIT_W = $clog2(ORDER_CREDITS + 1);

    logic [CREDIT_W-1:0] credits;
    payload_count_t      pos;
    logic                is_add;
    logic                take;

    // Captured fields and their values after this cycle's pop
    stock_id_t stock_q;
    stock_id_t stock_next;
    order_id_t order_id_q;
    order_id_t order_id_next;
    quantity_t qty_q;
    quantity_t qty_next;
    price_t    price_q;
    price_t    price_next;
    logic      buy_q;
    logic      buy_next;
    request_e  request;

    // A last byte waits until a record can be sent
    assign pop    = !fifo_empty && (!fifo_data.last || credits != '0);
    assign take   = pop && fifo_data.last;
    assign is_add = (fifo_data.kind == KIND_ADD);

    ////////////////////////////////////////
    // Field capture
    ////////////////////////////////////////

    always_comb begin
        stock_next    = stock_q;
        order_id_next = order_id_q;
        qty_next      = qty_q;
        price_next    = price_q;
        buy_next      = buy_q;
        if (pop) begin
            if (pos == OFS_STOCK) begin
                stock_next = fifo_data.data[1:0];
            end
            if (pos == OFS_ORDER_ID) begin
                order_id_next = fifo_data.data;
            end
            if (is_add && pos == OFS_SIDE) begin
                buy_next = (fifo_data.data == SIDE_BUY);
            end
            // Shares end one byte later in add, after the side byte
            if (pos == (is_add ? OFS_ADD_QTY : OFS_EXEC_QTY)) begin
                qty_next = fifo_data.data;
            end
            if (pos == OFS_PRICE_HI) begin
                price_next[15:8] = fifo_data.data;
            end
            if (pos == OFS_PRICE_LO) begin
                price_next[7:0] = fifo_data.data;
            end
        end
    end

    always_comb begin
        case (fifo_data.kind)
            KIND_ADD:     request = REQ_ADD;
            KIND_EXECUTE: request = REQ_EXECUTE;
            KIND_CANCEL:  request = REQ_CANCEL;
            default:      request = REQ_NONE;
        endcase
    end

    always_ff @(posedge clk_in) begin
        stock_q    <= stock_next;
        order_id_q <= order_id_next;
        qty_q      <= qty_next;
        price_q    <= price_next;
        buy_q      <= buy_next;
    end

    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            pos <= '0;
        end else if (pop) begin
            pos <= fifo_data.last ? '0 : pos + 6'd1;
        end
    end

    ////////////////////////////////////////
    // Record output
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (take) begin
            order_out.request  <= request;
            order_out.stock    <= stock_next;
            order_out.order_id <= order_id_next;
            order_out.quantity <= qty_next;
            order_out.price    <= is_add ? price_next : '0;
            order_out.buy      <= is_add && buy_next;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            order_valid <= 1'b0;
        end else begin
            order_valid <= take;
        end
    end

    // One credit spent per record, one back per order_credit pulse
    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            credits <= CREDIT_W'(ORDER_CREDITS);
        end else begin
            case ({order_valid, order_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/payload_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module payload_fifo
    import itch_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire          clk_in,
    input  wire          reset_in,
    input  wire          push,
    input  tagged_byte_t push_data,
    input  wire          pop,
    output tagged_byte_t fifo_data,
    output logic         fifo_empty,
    output logic         credit_return
);

    localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

    tagged_byte_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [COUNT_W-1:0]  count;
    logic                pop_ok;

    assign fifo_empty = (count == '0);
    assign fifo_data  = mem[rd_ptr];

    // Pop on empty is ignored
    assign pop_ok = pop && !fifo_empty;

    // Every pop frees a slot for the framer
    assign credit_return = pop_ok;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/msg_framer.sv
`timescale 1ns/100ps
`default_nettype none

module msg_framer
    import itch_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire          clk_in,
    input  wire          reset_in,
    input  wire byte_t   byte_in,
    input  wire          byte_valid,
    input  wire          credit_return,
    output logic         byte_ready,
    output logic         push,
    output tagged_byte_t push_data
);

    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

    framer_state_e       state;
    msg_kind_e           kind;
    payload_count_t      count;
    byte_t               skip_left;
    logic [CREDIT_W-1:0] credits;
    payload_count_t      payload_len;
    logic                accept;
    logic                last_byte;

    // Only payload bytes need FIFO space
    assign byte_ready = (state != PAYLOAD) || (credits != '0);
    assign accept     = byte_valid && byte_ready;

    assign payload_len = (kind == KIND_ADD) ? ADD_PAYLOAD_LEN : EXEC_PAYLOAD_LEN;
    assign last_byte   = (count == payload_len - 6'd1);

    assign push = accept && (state == PAYLOAD);

    always_comb begin
        push_data.kind = kind;
        push_data.last = last_byte;
        push_data.data = byte_in;
    end

    ////////////////////////////////////////
    // Message framing FSM
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            state     <= WAIT_LENGTH;
            kind      <= KIND_ADD;
            count     <= '0;
            skip_left <= '0;
        end else if (accept) begin
            case (state)
                WAIT_LENGTH: begin
                    // Zero bytes between messages are dropped
                    if (byte_in != 8'h00) begin
                        skip_left <= byte_in - 8'd1;
                        state     <= WAIT_TYPE;
                    end
                end
                WAIT_TYPE: begin
                    count <= '0;
                    case (byte_in)
                        MSG_ADD_BUY, MSG_ADD_ALT: begin
                            kind  <= KIND_ADD;
                            state <= PAYLOAD;
                        end
                        MSG_EXECUTE: begin
                            kind  <= KIND_EXECUTE;
                            state <= PAYLOAD;
                        end
                        MSG_CANCEL: begin
                            kind  <= KIND_CANCEL;
                            state <= PAYLOAD;
                        end
                        default: begin
                            // A length of one is a bare type byte
                            state <= (skip_left == '0) ? WAIT_LENGTH : SKIP;
                        end
                    endcase
                end
                PAYLOAD: begin
                    count <= count + 6'd1;
                    if (last_byte) begin
                        state <= WAIT_LENGTH;
                    end
                end
                SKIP: begin
                    skip_left <= skip_left - 8'd1;
                    if (skip_left == 8'd1) begin
                        state <= WAIT_LENGTH;
                    end
                end
                default: state <= WAIT_LENGTH;
            endcase
        end
    end

    // FIFO credits, one per free entry
    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            credits <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            case ({push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/itch_pkg.sv
`default_nettype none

package itch_pkg;

    ////////////////////////////////////////
    // Field types
    ////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  stock_id_t;
    typedef logic [7:0]  order_id_t;
    typedef logic [7:0]  quantity_t;
    typedef logic [15:0] price_t;
    typedef logic [5:0]  payload_count_t;

    typedef enum logic [2:0] {
        REQ_NONE    = 3'd0,
        REQ_ADD     = 3'd1,
        REQ_CANCEL  = 3'd2,
        REQ_EXECUTE = 3'd3
    } request_e;

    // Kind tag that travels with each payload byte
    typedef enum logic [1:0] {
        KIND_ADD     = 2'd0,
        KIND_EXECUTE = 2'd1,
        KIND_CANCEL  = 2'd2
    } msg_kind_e;

    typedef struct packed {
        msg_kind_e kind;
        logic      last;
        byte_t     data;
    } tagged_byte_t;

    typedef struct packed {
        request_e  request;
        stock_id_t stock;
        order_id_t order_id;
        quantity_t quantity;
        price_t    price;
        logic      buy;
    } order_rec_t;

    typedef enum logic [1:0] {
        WAIT_LENGTH,
        WAIT_TYPE,
        PAYLOAD,
        SKIP
    } framer_state_e;

    ////////////////////////////////////////
    // Message codes and layout
    ////////////////////////////////////////

    localparam byte_t MSG_ADD_BUY = 8'h82;
    localparam byte_t MSG_ADD_ALT = 8'h86;
    localparam byte_t MSG_EXECUTE = 8'h2A;
    localparam byte_t MSG_CANCEL  = 8'hA1;
    localparam byte_t SIDE_BUY    = 8'h41;

    // Payload sizes, not counting the type byte
    localparam payload_count_t ADD_PAYLOAD_LEN  = 6'd35;
    localparam payload_count_t EXEC_PAYLOAD_LEN = 6'd22;

    // Last byte of each big-endian field
    localparam payload_count_t OFS_STOCK    = 6'd1;
    localparam payload_count_t OFS_ORDER_ID = 6'd17;
    localparam payload_count_t OFS_SIDE     = 6'd18;
    localparam payload_count_t OFS_ADD_QTY  = 6'd22;
    localparam payload_count_t OFS_EXEC_QTY = 6'd21;
    localparam payload_count_t OFS_PRICE_HI = 6'd33;
    localparam payload_count_t OFS_PRICE_LO = 6'd34;

endpackage

`default_nettype wire
